// ==== tb.f ====
logic/laser_game_pkg.sv
logic/vga_timing.sv
logic/background_draw.sv
logic/laser_obstacle.sv
logic/hit_detect.sv
logic/laser_game_top.sv
sim/tb_laser_game.sv

// ==== sim/tb_laser_game.sv ====
`timescale 1ns/1ns
`default_nettype none

module tb_laser_game
  import laser_game_pkg::*;
();

  localparam int RAND_SEED  = 32'h22d1_70e5;
  localparam int FRAME_CLKS = H_TOTAL * V_TOTAL;
  localparam int SWEEP_CLKS = 6 * (LASER_HALF_MAX * (STEP_DELAY + 1) + HOLD_DELAY + 1);
  localparam int MAX_CYCLES = 2 * FRAME_CLKS + SWEEP_CLKS + 40_000;

  logic pclk, rst, start, play_selected, menu_on;
  logic [3:0]  level_sel;
  logic        hsync, vsync, working, done, hit;
  logic [11:0] rgb;
  logic [7:0]  hit_count;

  // reference model state
  logic [COUNT_W-1:0] m_h, m_v, p1_h, p1_v, p2_x, p2_y;
  logic               p1_hs, p1_vs, p1_live, p2_on;
  laser_state_t       m_state;
  int                 m_seq, m_width, m_timer, m_left, m_right;
  logic [11:0]        e_rgb;
  logic               e_hsync, e_vsync, e_done, e_hit;
  logic [7:0]         e_count;

  logic  cmp_en;
  int    cycles;
  int    start_pos;
  string test_name;

  laser_game_top dut (
    .pclk(pclk), .rst(rst), .start(start), .play_selected(play_selected),
    .menu_on(menu_on), .level_sel(level_sel), .hsync(hsync), .vsync(vsync),
    .rgb(rgb), .working(working), .done(done), .hit(hit), .hit_count(hit_count)
  );

  initial pclk = 1'b0;
  always #5 pclk = ~pclk;

  ////////////////////////////////////////
  // reference functions
  ////////////////////////////////////////
  function automatic laser_state_t state_of_beam(input int seq);
    case (seq)
      1, 4:    state_of_beam = DRAW_MIDDLE;
      2, 3:    state_of_beam = DRAW_RIGHT;
      default: state_of_beam = DRAW_LEFT;  // first and last beam
    endcase
  endfunction

  function automatic int column_of_beam(input int seq);
    case (seq)
      1, 4:    column_of_beam = LASER_MID_START;
      2, 3:    column_of_beam = LASER_RIGHT_START;
      default: column_of_beam = LASER_LEFT_START;
    endcase
  endfunction

  function automatic logic is_blank(input logic [COUNT_W-1:0] h, input logic [COUNT_W-1:0] v);
    is_blank = (h >= H_ACTIVE) || (v >= V_ACTIVE);
  endfunction

  function automatic logic beam_covers(input logic [COUNT_W-1:0] h,
                                      input logic [COUNT_W-1:0] v,
                                      input laser_state_t st, input int left, input int right);
    beam_covers = (st != IDLE) && (h >= left) && (h <= right) &&
                  (v >= LASER_TOP) && (v <= LASER_BOTTOM);
  endfunction

  // colour due two clocks after the counters show (h, v)
  function automatic logic [11:0] expected_rgb(input logic [COUNT_W-1:0] h,
                                               input logic [COUNT_W-1:0] v,
                                               input laser_state_t st,
                                               input int left, input int right);
    if (is_blank(h, v)) begin
      expected_rgb = 12'h000;
    end else if (beam_covers(h, v, st, left, right)) begin
      expected_rgb = LASER_COLOR;
    end else begin
      expected_rgb = BG_COLOR;
    end
  endfunction

  function automatic logic hit_due(input logic on, input logic [COUNT_W-1:0] x,
                                   input logic [COUNT_W-1:0] y);
    hit_due = on && (x >= PLAYER_X0) && (x <= PLAYER_X1) &&
              (y >= PLAYER_Y0) && (y <= PLAYER_Y1);
  endfunction

  assign m_left  = column_of_beam(m_seq) - m_width;
  assign m_right = column_of_beam(m_seq) + 1 + m_width;

  ////////////////////////////////////////
  // cycle model of the pixel path
  ////////////////////////////////////////
  always @(posedge pclk) begin
    if (rst) begin
      m_h     <= '0;
      m_v     <= '0;
      p1_h    <= '0;
      p1_v    <= '0;
      p1_hs   <= 1'b0;
      p1_vs   <= 1'b0;
      p1_live <= 1'b0;
      p2_on   <= 1'b0;
      p2_x    <= '0;
      p2_y    <= '0;
      m_state <= IDLE;
      m_seq   <= 0;
      m_width <= 0;
      m_timer <= 0;
      e_rgb   <= 12'h000;
      e_hsync <= 1'b0;
      e_vsync <= 1'b0;
      e_done  <= 1'b0;
      e_hit   <= 1'b0;
      e_count <= 8'd0;
    end else begin
      if (m_h == H_TOTAL - 1) begin
        m_h <= '0;
        m_v <= (m_v == V_TOTAL - 1) ? '0 : m_v + 1'b1;
      end else begin
        m_h <= m_h + 1'b1;
      end
      p1_h    <= m_h;
      p1_v    <= m_v;
      p1_hs   <= (m_h >= H_ACTIVE + H_FRONT) && (m_h < H_ACTIVE + H_FRONT + H_SYNC);
      p1_vs   <= (m_v >= V_ACTIVE + V_FRONT) && (m_v < V_ACTIVE + V_FRONT + V_SYNC);
      p1_live <= 1'b1;  // background stage is filled from here on
      e_hsync <= p1_hs;
      e_vsync <= p1_vs;
      e_rgb   <= p1_live ? expected_rgb(p1_h, p1_v, m_state, m_left, m_right) : 12'h000;
      p2_on   <= !is_blank(p1_h, p1_v) && beam_covers(p1_h, p1_v, m_state, m_left, m_right);
      p2_x    <= p1_h;
      p2_y    <= p1_v;
      e_hit   <= hit_due(p2_on, p2_x, p2_y);
      if (start && (m_state == IDLE)) begin
        e_count <= 8'd0;
      end else if (hit_due(p2_on, p2_x, p2_y) && (e_count != 8'hff)) begin
        e_count <= e_count + 1'b1;
      end
      e_done <= 1'b0;
      if (m_state == IDLE) begin
        if (start && play_selected && (level_sel == 4'd1)) begin
          m_state <= DRAW_LEFT;
          m_seq   <= 0;
          m_width <= 0;
          m_timer <= 0;
        end
      end else if (menu_on || !play_selected) begin
        m_state <= IDLE;  // abort
      end else if (m_width < LASER_HALF_MAX) begin
        if (m_timer == STEP_DELAY) begin
          m_width <= m_width + 1;
          m_timer <= 0;
        end else begin
          m_timer <= m_timer + 1;
        end
      end else if (m_timer == HOLD_DELAY) begin
        m_timer <= 0;
        m_width <= 0;
        if (m_seq == 5) begin
          m_state <= IDLE;
          e_done  <= 1'b1;
        end else begin
          m_seq   <= m_seq + 1;
          m_state <= state_of_beam(m_seq + 1);
        end
      end else begin
        m_timer <= m_timer + 1;
      end
    end
  end

  ////////////////////////////////////////
  // compare tasks
  ////////////////////////////////////////
  task automatic stop_with_failure(input string msg);
    $display("%s", msg);
    $display(">>> FAIL");
    $fatal(1);
  endtask

  task automatic check_rgb(input string what, input logic [11:0] exp, input logic [11:0] act);
    if (act !== exp) begin
      stop_with_failure($sformatf("Mismatch in %s: %s expected %h actual %h",
                                  test_name, what, exp, act));
    end
  endtask

  task automatic check_bit(input string what, input logic exp, input logic act);
    if (act !== exp) begin
      stop_with_failure($sformatf("Mismatch in %s: %s expected %b actual %b",
                                  test_name, what, exp, act));
    end
  endtask

  task automatic check_count(input string what, input logic [7:0] exp, input logic [7:0] act);
    if (act !== exp) begin
      stop_with_failure($sformatf("Mismatch in %s: %s expected %0d actual %0d",
                                  test_name, what, exp, act));
    end
  endtask

  // compare mid cycle
  always @(negedge pclk) begin
    if (cmp_en) begin
      check_rgb("rgb", e_rgb, rgb);
      check_bit("hsync", e_hsync, hsync);
      check_bit("vsync", e_vsync, vsync);
      check_bit("working", m_state != IDLE, working);
      check_bit("done", e_done, done);
      check_bit("hit", e_hit, hit);
      check_count("hit_count", e_count, hit_count);
    end
  end

  always @(posedge pclk) begin
    cycles <= cycles + 1;
    if (cycles >= MAX_CYCLES) begin
      stop_with_failure("the run timed out before all tests completed");
    end
  end

  ////////////////////////////////////////
  // stimulus
  ////////////////////////////////////////
  initial begin
    rst           = 1'b1;
    start         = 1'b0;
    play_selected = 1'b0;
    menu_on       = 1'b0;
    level_sel     = 4'd0;
    cmp_en        = 1'b0;
    cycles        = 0;
    test_name     = "reset";
    start_pos     = $urandom(RAND_SEED);
    start_pos     = 650_000 + int'($urandom % 10_000);  // lines up the left beam with the box
    @(posedge pclk);
    cmp_en = 1'b1;
    repeat (2) @(posedge pclk);
    rst <= 1'b0;

    test_name = "idle_background";
    repeat (3000) @(posedge pclk);

    test_name     = "start_wrong_level";
    play_selected <= 1'b1;
    level_sel     <= 4'd2;
    start         <= 1'b1;
    repeat (20) @(posedge pclk);
    start <= 1'b0;
    repeat (100) @(posedge pclk);

    test_name     = "start_without_play";
    play_selected <= 1'b0;
    level_sel     <= 4'd1;
    start         <= 1'b1;
    repeat (20) @(posedge pclk);
    start <= 1'b0;
    repeat (100) @(posedge pclk);

    test_name     = "full_sweep";
    play_selected <= 1'b1;
    while ((m_v * H_TOTAL + m_h) != start_pos) @(posedge pclk);
    start <= 1'b1;
    repeat (4) @(posedge pclk);
    start <= 1'b0;
    while (done !== 1'b1) @(posedge pclk);
    repeat (10) @(posedge pclk);
    if (e_count == 8'd0) begin
      stop_with_failure("the sweep never put a laser pixel on the player box");
    end

    // restart clears the count, then the menu aborts mid beam
    test_name = "menu_abort";
    while (!((m_v == 300) && (m_h == 0))) @(posedge pclk);
    start <= 1'b1;
    repeat (4) @(posedge pclk);
    start <= 1'b0;
    repeat (40_000) @(posedge pclk);
    menu_on <= 1'b1;
    repeat (5) @(posedge pclk);
    menu_on <= 1'b0;
    repeat (2000) @(posedge pclk);

    $display(">>> PASS");
    $finish;
  end

endmodule

`default_nettype wire

// ==== logic/laser_game_top.sv ====
`timescale 1ns/1ns
`default_nettype none

module laser_game_top
  import laser_game_pkg::*;
(
  input  wire logic        pclk,
  input  wire logic        rst,
  input  wire logic        start,
  input  wire logic        play_selected,
  input  wire logic        menu_on,
  input  wire logic [3:0]  level_sel,
  output logic             hsync,
  output logic             vsync,
  output logic [11:0]      rgb,
  output logic             working,
  output logic             done,
  output logic             hit,
  output logic [7:0]       hit_count
);

  // timing generator outputs
  logic [COUNT_W-1:0] hcount_t, vcount_t;
  logic               hsync_t, vsync_t, blank_t;

  // background stage outputs
  logic [COUNT_W-1:0] hcount_b, vcount_b;
  logic               hsync_b, vsync_b, blank_b;
  logic [11:0]        rgb_b;

  // laser pixel report
  logic               obstacle_on;
  logic [COUNT_W-1:0] obstacle_x, obstacle_y;

  ////////////////////////////////////////
  // pixel path
  ////////////////////////////////////////
  vga_timing u_vga_timing (
    .pclk   (pclk),
    .rst    (rst),
    .hcount (hcount_t),
    .vcount (vcount_t),
    .hsync  (hsync_t),
    .vsync  (vsync_t),
    .blank  (blank_t)
  );

  background_draw u_background_draw (
    .pclk       (pclk),
    .rst        (rst),
    .hcount_in  (hcount_t),
    .vcount_in  (vcount_t),
    .hsync_in   (hsync_t),
    .vsync_in   (vsync_t),
    .blank_in   (blank_t),
    .hcount_out (hcount_b),
    .vcount_out (vcount_b),
    .hsync_out  (hsync_b),
    .vsync_out  (vsync_b),
    .blank_out  (blank_b),
    .rgb_out    (rgb_b)
  );

  laser_obstacle u_laser_obstacle (
    .pclk          (pclk),
    .rst           (rst),
    .hcount_in     (hcount_b),
    .vcount_in     (vcount_b),
    .hsync_in      (hsync_b),
    .vsync_in      (vsync_b),
    .blank_in      (blank_b),
    .rgb_in        (rgb_b),
    .start         (start),
    .play_selected (play_selected),
    .menu_on       (menu_on),
    .level_sel     (level_sel),
    .hsync_out     (hsync),
    .vsync_out     (vsync),
    .rgb_out       (rgb),
    .obstacle_on   (obstacle_on),
    .obstacle_x    (obstacle_x),
    .obstacle_y    (obstacle_y),
    .working       (working),
    .done          (done)
  );

  // consumer of the laser pixels
  hit_detect u_hit_detect (
    .pclk        (pclk),
    .rst         (rst),
    .obstacle_on (obstacle_on),
    .obstacle_x  (obstacle_x),
    .obstacle_y  (obstacle_y),
    .start       (start),
    .working     (working),
    .hit         (hit),
    .hit_count   (hit_count)
  );

endmodule

`default_nettype wire

// ==== logic/hit_detect.sv ====
`timescale 1ns/1ns
`default_nettype none

module hit_detect
  import laser_game_pkg::*;
(
  input  wire logic               pclk,
  input  wire logic               rst,
  input  wire logic               obstacle_on,
  input  wire logic [COUNT_W-1:0] obstacle_x,
  input  wire logic [COUNT_W-1:0] obstacle_y,
  input  wire logic               start,
  input  wire logic               working,
  output logic                    hit,
  output logic [7:0]              hit_count
);

  logic in_box;

  ////////////////////////////////////////
  // player box test
  ////////////////////////////////////////
  assign in_box = obstacle_on &&
                  (obstacle_x >= PLAYER_X0) && (obstacle_x <= PLAYER_X1) &&
                  (obstacle_y >= PLAYER_Y0) && (obstacle_y <= PLAYER_Y1);

  always_ff @(posedge pclk) begin
    if (rst) begin
      hit <= 1'b0;
    end else begin
      hit <= in_box;  // one clock pulse per laser pixel
    end
  end

  // saturating count, cleared by a fresh start
  always_ff @(posedge pclk) begin
    if (rst) begin
      hit_count <= 8'd0;
    end else if (start && !working) begin
      hit_count <= 8'd0;
    end else if (in_box && (hit_count != 8'hff)) begin
      hit_count <= hit_count + 1'b1;
    end
  end

  ////////////////////////////////////////
  // checks
  ////////////////////////////////////////
  // a hit always comes from a reported laser pixel one clock earlier
  a_hit_source: assert property (
    @(posedge pclk) disable iff (rst)
    hit |-> $past(obstacle_on)
  );

endmodule

`default_nettype wire

// ==== logic/laser_obstacle.sv ====
`timescale 1ns/1ns
`default_nettype none

module laser_obstacle
  import laser_game_pkg::*;
(
  input  wire logic               pclk,
  input  wire logic               rst,
  input  wire logic [COUNT_W-1:0] hcount_in,
  input  wire logic [COUNT_W-1:0] vcount_in,
  input  wire logic               hsync_in,
  input  wire logic               vsync_in,
  input  wire logic               blank_in,
  input  wire logic [11:0]        rgb_in,
  input  wire logic               start,
  input  wire logic               play_selected,
  input  wire logic               menu_on,
  input  wire logic [3:0]         level_sel,
  output logic                    hsync_out,
  output logic                    vsync_out,
  output logic [11:0]             rgb_out,
  output logic                    obstacle_on,
  output logic [COUNT_W-1:0]      obstacle_x,
  output logic [COUNT_W-1:0]      obstacle_y,
  output logic                    working,
  output logic                    done
);

  laser_state_t state, state_nxt;

  logic [COUNT_W-1:0] laser_left, laser_right;
  logic [COUNT_W-1:0] laser_left_nxt, laser_right_nxt;
  logic [$clog2(STEP_DELAY+1)-1:0] step_cnt, step_cnt_nxt;
  logic [$clog2(HOLD_DELAY+1)-1:0] hold_cnt, hold_cnt_nxt;
  logic               bounce_back, bounce_back_nxt;
  logic               done_nxt;
  logic               beam_full;
  logic               in_beam;

  // left edge each beam grows from
  function automatic logic [COUNT_W-1:0] beam_origin(input laser_state_t s);
    case (s)
      DRAW_MIDDLE: beam_origin = COUNT_W'(LASER_MID_START);
      DRAW_RIGHT:  beam_origin = COUNT_W'(LASER_RIGHT_START);
      default:     beam_origin = COUNT_W'(LASER_LEFT_START);
    endcase
  endfunction

  assign beam_full = (laser_left + LASER_HALF_MAX) <= beam_origin(state);
  assign working   = (state != IDLE);

  ////////////////////////////////////////
  // state and beam registers
  ////////////////////////////////////////
  always_ff @(posedge pclk) begin
    if (rst) begin
      state       <= IDLE;
      laser_left  <= '0;
      laser_right <= '0;
      step_cnt    <= '0;
      hold_cnt    <= '0;
      bounce_back <= 1'b0;
      done        <= 1'b0;
    end else begin
      state       <= state_nxt;
      laser_left  <= laser_left_nxt;
      laser_right <= laser_right_nxt;
      step_cnt    <= step_cnt_nxt;
      hold_cnt    <= hold_cnt_nxt;
      bounce_back <= bounce_back_nxt;
      done        <= done_nxt;
    end
  end

  always_comb begin
    state_nxt       = state;
    laser_left_nxt  = laser_left;
    laser_right_nxt = laser_right;
    step_cnt_nxt    = step_cnt;
    hold_cnt_nxt    = hold_cnt;
    bounce_back_nxt = bounce_back;
    done_nxt        = 1'b0;
    case (state)
      IDLE: begin
        step_cnt_nxt    = '0;
        hold_cnt_nxt    = '0;
        bounce_back_nxt = 1'b0;
        if (start && play_selected && (level_sel == 4'd1)) begin
          state_nxt = DRAW_LEFT;
        end
      end
      default: begin
        if (menu_on || !play_selected) begin
          state_nxt    = IDLE;  // abort, no done
          step_cnt_nxt = '0;
          hold_cnt_nxt = '0;
        end else if (!beam_full) begin
          // widen one pixel per side each step
          if (step_cnt == STEP_DELAY) begin
            step_cnt_nxt    = '0;
            laser_left_nxt  = laser_left - 1'b1;
            laser_right_nxt = laser_right + 1'b1;
          end else begin
            step_cnt_nxt = step_cnt + 1'b1;
          end
        end else if (hold_cnt == HOLD_DELAY) begin
          hold_cnt_nxt = '0;
          step_cnt_nxt = '0;
          // left, middle, right, right, middle, left
          case (state)
            DRAW_LEFT: begin
              if (bounce_back) begin
                state_nxt = IDLE;
                done_nxt  = 1'b1;
              end else begin
                state_nxt = DRAW_MIDDLE;
              end
            end
            DRAW_MIDDLE: state_nxt = bounce_back ? DRAW_LEFT : DRAW_RIGHT;
            default: begin
              state_nxt       = bounce_back ? DRAW_MIDDLE : DRAW_RIGHT;
              bounce_back_nxt = 1'b1;  // second right turns the sweep
            end
          endcase
        end else begin
          hold_cnt_nxt = hold_cnt + 1'b1;
        end
      end
    endcase
    // every new beam starts 2 pixels wide
    if ((state_nxt != IDLE) && (state_nxt != state || hold_cnt_nxt != hold_cnt) &&
        (hold_cnt_nxt == '0) && (step_cnt_nxt == '0) && (state == IDLE || beam_full)) begin
      laser_left_nxt  = beam_origin(state_nxt);
      laser_right_nxt = beam_origin(state_nxt) + 1'b1;
    end
  end

  ////////////////////////////////////////
  // pixel overlay
  ////////////////////////////////////////
  assign in_beam = working && !blank_in &&
                   (hcount_in >= laser_left) && (hcount_in <= laser_right) &&
                   (vcount_in >= LASER_TOP) && (vcount_in <= LASER_BOTTOM);

  always_ff @(posedge pclk) begin
    if (rst) begin
      hsync_out   <= 1'b0;
      vsync_out   <= 1'b0;
      rgb_out     <= 12'h000;
      obstacle_on <= 1'b0;
    end else begin
      hsync_out   <= hsync_in;
      vsync_out   <= vsync_in;
      rgb_out     <= in_beam ? LASER_COLOR : rgb_in;
      obstacle_on <= in_beam;
    end
  end

  always_ff @(posedge pclk) begin
    obstacle_x <= hcount_in;  // valid with obstacle_on
    obstacle_y <= vcount_in;
  end

  // edges never cross
  a_edges_ordered: assert property (
    @(posedge pclk) disable iff (rst)
    laser_left <= laser_right
  );

  a_done_single: assert property (
    @(posedge pclk) disable iff (rst)
    done |=> !done
  );

endmodule

`default_nettype wire

// ==== logic/background_draw.sv ====
`timescale 1ns/1ns
`default_nettype none

module background_draw
  import laser_game_pkg::*;
(
  input  wire logic               pclk,
  input  wire logic               rst,
  input  wire logic [COUNT_W-1:0] hcount_in,
  input  wire logic [COUNT_W-1:0] vcount_in,
  input  wire logic               hsync_in,
  input  wire logic               vsync_in,
  input  wire logic               blank_in,
  output logic [COUNT_W-1:0]      hcount_out,
  output logic [COUNT_W-1:0]      vcount_out,
  output logic                    hsync_out,
  output logic                    vsync_out,
  output logic                    blank_out,
  output logic [11:0]             rgb_out
);

  ////////////////////////////////////////
  // one clock pixel stage
  ////////////////////////////////////////
  always_ff @(posedge pclk) begin
    if (rst) begin
      hsync_out <= 1'b0;
      vsync_out <= 1'b0;
      blank_out <= 1'b0;
      rgb_out   <= 12'h000;
    end else begin
      hsync_out <= hsync_in;
      vsync_out <= vsync_in;
      blank_out <= blank_in;
      // black outside the visible area, later stages only overlay
      if (blank_in) begin
        rgb_out <= 12'h000;
      end else begin
        rgb_out <= BG_COLOR;
      end
    end
  end

  // counts carry no state of their own
  always_ff @(posedge pclk) begin
    if (rst) begin
      hcount_out <= '0;
      vcount_out <= '0;
    end else begin
      hcount_out <= hcount_in;  // same delay as rgb
      vcount_out <= vcount_in;
    end
  end

endmodule

`default_nettype wire

// ==== logic/vga_timing.sv ====
`timescale 1ns/1ns
`default_nettype none

module vga_timing
  import laser_game_pkg::*;
(
  input  wire logic               pclk,
  input  wire logic               rst,
  output logic [COUNT_W-1:0]      hcount,
  output logic [COUNT_W-1:0]      vcount,
  output logic                    hsync,
  output logic                    vsync,
  output logic                    blank
);

  logic [COUNT_W-1:0] hcount_nxt;
  logic [COUNT_W-1:0] vcount_nxt;

  ////////////////////////////////////////
  // free running counters
  ////////////////////////////////////////
  always_comb begin
    if (hcount == COUNT_W'(H_TOTAL - 1)) begin
      hcount_nxt = '0;
      if (vcount == COUNT_W'(V_TOTAL - 1)) begin
        vcount_nxt = '0;  // end of frame
      end else begin
        vcount_nxt = vcount + 1'b1;
      end
    end else begin
      hcount_nxt = hcount + 1'b1;
      vcount_nxt = vcount;
    end
  end

  // sync and blank are decoded from the next count,
  // so they line up with the registered counters
  always_ff @(posedge pclk) begin
    if (rst) begin
      hcount <= '0;
      vcount <= '0;
      hsync  <= 1'b0;
      vsync  <= 1'b0;
      blank  <= 1'b0;
    end else begin
      hcount <= hcount_nxt;
      vcount <= vcount_nxt;
      hsync  <= (hcount_nxt >= H_ACTIVE + H_FRONT) &&
                (hcount_nxt <  H_ACTIVE + H_FRONT + H_SYNC);
      vsync  <= (vcount_nxt >= V_ACTIVE + V_FRONT) &&
                (vcount_nxt <  V_ACTIVE + V_FRONT + V_SYNC);
      blank  <= (hcount_nxt >= H_ACTIVE) || (vcount_nxt >= V_ACTIVE);
    end
  end

  ////////////////////////////////////////
  // checks
  ////////////////////////////////////////
  // counters stay inside the frame
  a_count_range: assert property (
    @(posedge pclk) disable iff (rst)
    (hcount < H_TOTAL) && (vcount < V_TOTAL)
  );

endmodule

`default_nettype wire

// ==== logic/laser_game_pkg.sv ====
`default_nettype none

package laser_game_pkg;

  ////////////////////////////////////////
  // screen timing, 1024x768
  ////////////////////////////////////////
  localparam int COUNT_W  = 12;

  localparam int H_ACTIVE = 1024;
  localparam int H_FRONT  = 24;
  localparam int H_SYNC   = 136;
  localparam int H_TOTAL  = 1344;

  localparam int V_ACTIVE = 768;
  localparam int V_FRONT  = 3;
  localparam int V_SYNC   = 6;
  localparam int V_TOTAL  = 806;

  ////////////////////////////////////////
  // laser geometry and pacing
  ////////////////////////////////////////
  localparam int LASER_TOP         = 317;
  localparam int LASER_BOTTOM      = 617;
  localparam int LASER_LEFT_START  = 411;  // right edge starts one higher
  localparam int LASER_MID_START   = 511;
  localparam int LASER_RIGHT_START = 611;
  localparam int LASER_HALF_MAX    = 30;   // widening per side

  localparam int STEP_DELAY = 999;    // clocks between widening steps
  localparam int HOLD_DELAY = 19999;  // full beam stays this long

  // colours, 4 bits per channel
  localparam logic [11:0] BG_COLOR    = 12'h124;
  localparam logic [11:0] LASER_COLOR = 12'hfff;

  // fixed player box, inclusive edges
  localparam int PLAYER_X0 = 440;
  localparam int PLAYER_X1 = 470;
  localparam int PLAYER_Y0 = 500;
  localparam int PLAYER_Y1 = 560;

  typedef enum logic [1:0] {
    IDLE        = 2'b00,
    DRAW_LEFT   = 2'b01,
    DRAW_MIDDLE = 2'b10,
    DRAW_RIGHT  = 2'b11
  } laser_state_t;

endpackage

`default_nettype wire
